//--- common/audPcm_cfg.svh
//############################################################################
// device select is matched against bus address bits 27..16
// rate values are divider reloads, so a sample period is reload + 1 cycles
//############################################################################
`ifndef AUD_PCM_CFG_SVH
`define AUD_PCM_CFG_SVH

// device select, compared with addr[27:16]
`define AUD_DEV_SEL 12'h009

// depth of each 32-bit sample bank
`define AUD_MEM_WORDS 1024

// divider reload per rate code
`define AUD_RATE_0 14'd12500
`define AUD_RATE_1 14'd9070
`define AUD_RATE_2 14'd6250
`define AUD_RATE_3 14'd4535
`define AUD_RATE_4 14'd3125
`define AUD_RATE_5 14'd2268
`define AUD_RATE_6 14'd1562
`define AUD_RATE_7 14'd1134
`define AUD_RATE_8 14'd781
`define AUD_RATE_9 14'd2083
`define AUD_RATE_10 14'd781
`define AUD_RATE_11 14'd1042
`define AUD_RATE_12 14'd781
`define AUD_RATE_13 14'd781
`define AUD_RATE_14 14'd781
// 1024-cycle period, handy in simulation
`define AUD_RATE_15 14'd1023

// bus opcode bits
`define AUD_OPM_WRITE 4
`define AUD_OPM_READ 3

`endif

//--- common/memBusPkg.sv
//############################################################################
// plain memory bus: request held one cycle, no back-pressure
// the response status is READY when idle and OK for an accepted access
//############################################################################
package memBusPkg;

	// response status codes
	typedef enum logic [1:0]
	{
		READY = 2'b00,
		OK = 2'b01
	} busStatus_e;

	// one bus access from the CPU side
	typedef struct packed
	{
		logic [31:0] addr;
		logic [31:0] data;
		logic [4:0] opm;
	} busReq_t;

	// registered answer to an access
	typedef struct packed
	{
		logic [31:0] data;
		busStatus_e status;
	} busResp_t;

endpackage

//--- common/audPcmPkg.sv
//############################################################################
// types of the PCM sound device
// control bit0 selects companding and bit1 selects 16-bit samples
//############################################################################
package audPcmPkg;

	// sample encoding in memory
	typedef enum logic [1:0]
	{
		LINEAR8 = 2'b00,
		COMPAND8 = 2'b01,
		LINEAR16 = 2'b10
	} sampleFormat_e;

	// control word, reserved fields read back as written
	typedef struct packed
	{
		logic [23:0] reserved;
		logic [3:0] rate;
		logic enable;
		logic stereoRsvd;
		sampleFormat_e format;
	} audCtrl_t;

	// offset-binary PWM level, 0x8000 is silence
	typedef logic [15:0] pcmLevel_t;

	// one PWM bit per channel
	typedef struct packed
	{
		logic right;
		logic left;
	} pwmPair_t;

endpackage

//--- audPcm/audRegBank.sv
//############################################################################
// bus side of the device: control register and two 32-bit sample banks
// response appears 2 cycles after the request, memory is not cleared
//############################################################################
`timescale 1ns/10ps
`include "audPcm_cfg.svh"

module audRegBank
(
	input logic clock,
	input logic reset,
	input memBusPkg::busReq_t busReq,
	output memBusPkg::busResp_t busResp,
	output audPcmPkg::audCtrl_t ctrl,
	input logic [9:0] blockIndex,
	output logic [63:0] block
);
	import memBusPkg::*;
	import audPcmPkg::*;

	busReq_t reqQ;
	busResp_t respNext;

	logic devSel;
	logic ctrlSel;
	logic ctrlOffset;
	logic sampleSel;
	logic isWrite;
	logic isRead;

	// bank A is the low word of a block, bank B the high word
	logic [31:0] memA [`AUD_MEM_WORDS];
	logic [31:0] memB [`AUD_MEM_WORDS];

	// address decode works on the registered request
	assign devSel = (reqQ.addr[27:16] == `AUD_DEV_SEL);
	assign ctrlSel = (reqQ.addr[15:12] == 4'hF);
	assign ctrlOffset = (reqQ.addr[7:2] == 6'h00);
	assign sampleSel = (reqQ.addr[15:14] == 2'b00);
	assign isWrite = reqQ.opm[`AUD_OPM_WRITE];
	assign isRead = reqQ.opm[`AUD_OPM_READ];

	always_comb
	begin
		respNext.status = READY;
		respNext.data = '0;

		if (devSel && (isWrite || isRead))
		begin
			respNext.status = OK;
		end

		// only the control word is readable
		if (devSel && isRead && ctrlSel && ctrlOffset)
		begin
			respNext.data = ctrl;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqQ <= '0;
			ctrl <= '0;
			busResp.data <= '0;
			busResp.status <= READY;
		end
		else
		begin
			reqQ <= busReq;
			busResp <= respNext;

			if (devSel && isWrite && ctrlSel && ctrlOffset)
			begin
				ctrl <= audCtrl_t'(reqQ.data);
			end
		end
	end

	// sample writes and the block read port
	always_ff @(posedge clock)
	begin
		if (devSel && isWrite && sampleSel)
		begin
			if (reqQ.addr[2])
			begin
				memB[reqQ.addr[12:3]] <= reqQ.data;
			end
			else
			begin
				memA[reqQ.addr[12:3]] <= reqQ.data;
			end
		end

		block <= {memB[blockIndex], memA[blockIndex]};
	end

endmodule

//--- audPcm/audSampleClock.sv
//############################################################################
// sample rate divider, a new rate is used from the next reload on
//############################################################################
`timescale 1ns/10ps
`include "audPcm_cfg.svh"

module audSampleClock
(
	input logic clock,
	input logic reset,
	input logic [3:0] rate,
	output logic [12:0] samplePos
);
	logic [13:0] reloadNext;
	logic [13:0] reloadQ;
	logic [13:0] divCnt;

	// rate code to divider reload
	always_comb
	begin
		case (rate)
			4'd0: reloadNext = `AUD_RATE_0;
			4'd1: reloadNext = `AUD_RATE_1;
			4'd2: reloadNext = `AUD_RATE_2;
			4'd3: reloadNext = `AUD_RATE_3;
			4'd4: reloadNext = `AUD_RATE_4;
			4'd5: reloadNext = `AUD_RATE_5;
			4'd6: reloadNext = `AUD_RATE_6;
			4'd7: reloadNext = `AUD_RATE_7;
			4'd8: reloadNext = `AUD_RATE_8;
			4'd9: reloadNext = `AUD_RATE_9;
			4'd10: reloadNext = `AUD_RATE_10;
			4'd11: reloadNext = `AUD_RATE_11;
			4'd12: reloadNext = `AUD_RATE_12;
			4'd13: reloadNext = `AUD_RATE_13;
			4'd14: reloadNext = `AUD_RATE_14;
			default: reloadNext = `AUD_RATE_15;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reloadQ <= '0;
			divCnt <= '0;
			samplePos <= '0;
		end
		else
		begin
			reloadQ <= reloadNext;
			// count down, step the position when the counter wraps
			if (divCnt == 14'd0)
			begin
				divCnt <= reloadQ;
				samplePos <= samplePos + 13'd1;
			end
			else
			begin
				divCnt <= divCnt - 14'd1;
			end
		end
	end

endmodule

//--- audPcm/audSampleDecoder.sv
//############################################################################
// sample fetch and expansion, 3 cycles from a position change to a value
// stored samples are offset binary, the output is signed 16-bit
//############################################################################
`timescale 1ns/10ps

module audSampleDecoder
(
	input logic clock,
	input logic reset,
	input audPcmPkg::sampleFormat_e format,
	input logic [12:0] samplePos,
	output logic [9:0] blockIndex,
	input logic [63:0] block,
	output logic [15:0] sampleValue
);
	logic is16Bit;
	logic isCompand;

	// position bits aligned with the block read
	logic [2:0] posQ;
	logic [7:0] samp8Q;
	logic [15:0] samp16Q;

	logic [10:0] mag11;
	logic [11:0] comp12;
	logic [11:0] value12;

	// bit1 of the format picks 16-bit, bit0 picks companding
	assign is16Bit = format[1];
	assign isCompand = format[0];

	// eight bytes or four halfwords per 64-bit block
	assign blockIndex = is16Bit ? samplePos[11:2] : samplePos[12:3];

	// S.E3.M4 segment expansion, exponent 0 is denormal
	always_comb
	begin
		case (samp8Q[6:4])
			3'd0: mag11 = {7'h00, samp8Q[3:0]};
			3'd1: mag11 = {7'h01, samp8Q[3:0]};
			3'd2: mag11 = {6'h01, samp8Q[3:0], samp8Q[3]};
			3'd3: mag11 = {5'h01, samp8Q[3:0], samp8Q[3:2]};
			3'd4: mag11 = {4'h1, samp8Q[3:0], samp8Q[3:1]};
			3'd5: mag11 = {3'h1, samp8Q[3:0], samp8Q[3:0]};
			3'd6: mag11 = {2'h1, samp8Q[3:0], samp8Q[3:0], 1'b0};
			default: mag11 = {1'b1, samp8Q[3:0], samp8Q[3:0], 2'b00};
		endcase
	end

	always_comb
	begin
		// sign folds the magnitude around zero
		if (samp8Q[7])
		begin
			comp12 = {~mag11, ~mag11[10]};
		end
		else
		begin
			comp12 = {mag11, mag11[10]};
		end

		if (is16Bit)
		begin
			// companding bit set keeps the sign as stored
			value12 = {samp16Q[15] ^ ~isCompand, samp16Q[14:4]};
		end
		else if (isCompand)
		begin
			value12 = comp12;
		end
		else
		begin
			value12 = {~samp8Q[7], samp8Q[6:0], 4'h0};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			posQ <= '0;
			sampleValue <= '0;
		end
		else
		begin
			posQ <= samplePos[2:0];
			// widen by repeating the top nibble
			sampleValue <= {value12, value12[11:8]};
		end
	end

	// byte and halfword select
	always_ff @(posedge clock)
	begin
		samp8Q <= block[{posQ, 3'b000} +: 8];
		samp16Q <= block[{posQ[1:0], 4'b0000} +: 16];
	end

endmodule

//--- audPcm/audMixPwm.sv
//############################################################################
// aux mix and first-order PWM per channel, sums wrap without saturation
// accumulators stay cleared while the output is disabled
//############################################################################
`timescale 1ns/10ps

module audMixPwm
(
	input logic clock,
	input logic reset,
	input logic [15:0] sampleValue,
	input logic [7:0] auxLeft,
	input logic [7:0] auxRight,
	input logic enable,
	output audPcmPkg::pwmPair_t pwmOut,
	output logic pwmEnable
);
	import audPcmPkg::*;

	// channel 0 is left, channel 1 is right
	logic [15:0] sampleQ;
	logic [1:0][7:0] auxQ;
	logic [1:0][15:0] sumQ;
	pcmLevel_t [1:0] levelQ;
	logic [1:0][15:0] acc;
	logic [1:0][15:0] accNext;
	logic [1:0] carry;

	// the carry out of each accumulator is the PWM bit
	always_comb
	begin
		for (int ch = 0; ch < 2; ch++)
		begin
			{carry[ch], accNext[ch]} = {1'b0, acc[ch]} + {1'b0, levelQ[ch]};
		end
	end

	// mix pipeline
	always_ff @(posedge clock)
	begin
		sampleQ <= sampleValue;
		auxQ <= {auxRight, auxLeft};
		for (int ch = 0; ch < 2; ch++)
		begin
			sumQ[ch] <= {{4{sampleQ[15]}}, sampleQ[15:4]}
				+ {{4{auxQ[ch][7]}}, auxQ[ch], 4'h0};
			// signed to offset binary
			levelQ[ch] <= {~sumQ[ch][15], sumQ[ch][14:0]};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			acc <= '0;
			pwmOut.right <= 1'b1;
			pwmOut.left <= 1'b1;
			pwmEnable <= 1'b0;
		end
		else
		begin
			pwmEnable <= enable;
			if (enable)
			begin
				acc <= accNext;
				pwmOut.right <= carry[1];
				pwmOut.left <= carry[0];
			end
			else
			begin
				// idle level is both ones
				acc <= '0;
				pwmOut.right <= 1'b1;
				pwmOut.left <= 1'b1;
			end
		end
	end

endmodule

//--- audPcm/audPcmDevice.sv
//############################################################################
// mono PCM sound device, left and right differ only by their aux inputs
//############################################################################
`timescale 1ns/10ps

module audPcmDevice
(
	input logic clock,
	input logic reset,
	input memBusPkg::busReq_t busReq,
	output memBusPkg::busResp_t busResp,
	input logic [7:0] auxLeft,
	input logic [7:0] auxRight,
	output audPcmPkg::pwmPair_t pwmOut,
	output logic pwmEnable
);
	import audPcmPkg::*;

	audCtrl_t ctrl;
	logic [9:0] blockIndex;
	logic [63:0] block;
	logic [12:0] samplePos;
	logic [15:0] sampleValue;

	audRegBank regBank_i
	(
		.clock(clock),
		.reset(reset),
		.busReq(busReq),
		.busResp(busResp),
		.ctrl(ctrl),
		.blockIndex(blockIndex),
		.block(block)
	);

	audSampleClock sampleClock_i
	(
		.clock(clock),
		.reset(reset),
		.rate(ctrl.rate),
		.samplePos(samplePos)
	);

	audSampleDecoder sampleDecoder_i
	(
		.clock(clock),
		.reset(reset),
		.format(ctrl.format),
		.samplePos(samplePos),
		.blockIndex(blockIndex),
		.block(block),
		.sampleValue(sampleValue)
	);

	audMixPwm mixPwm_i
	(
		.clock(clock),
		.reset(reset),
		.sampleValue(sampleValue),
		.auxLeft(auxLeft),
		.auxRight(auxRight),
		.enable(ctrl.enable),
		.pwmOut(pwmOut),
		.pwmEnable(pwmEnable)
	);

endmodule

//--- test/audPcmDeviceTb.sv
//############################################################################
// run from the project root, test/audPcmGolden.txt holds one test per line
// each test waits two slowest sample periods before counting PWM ones
//############################################################################
`timescale 1ns/10ps
`include "audPcm_cfg.svh"

module audPcmDeviceTb;
	import memBusPkg::*;
	import audPcmPkg::*;

	localparam int slowPeriod = `AUD_RATE_0 + 1;
	localparam int settleCycles = 2 * slowPeriod + 10;
	localparam int countCycles = 65536;
	localparam int fillWrites = 2 * `AUD_MEM_WORDS;
	localparam int maxTests = 32;
	localparam logic [31:0] devBase = {4'h0, `AUD_DEV_SEL, 16'h0000};
	localparam logic [31:0] ctrlAddr = devBase | 32'h0000_F000;
	localparam logic [31:0] otherAddr = ctrlAddr ^ 32'h0001_0000;
	localparam logic [4:0] opmWrite = 5'(1 << `AUD_OPM_WRITE);
	localparam logic [4:0] opmRead = 5'(1 << `AUD_OPM_READ);

	logic clock;
	logic reset;
	busReq_t busReq;
	busResp_t busResp;
	logic [7:0] auxLeft;
	logic [7:0] auxRight;
	pwmPair_t pwmOut;
	logic pwmEnable;

	int errors;
	int numTests;
	int fillOrder [fillWrites];

	// golden file columns
	string testName [maxTests];
	logic [31:0] ctrlWord [maxTests];
	logic [15:0] patA [maxTests];
	logic [15:0] patB [maxTests];
	logic [7:0] auxL [maxTests];
	logic [7:0] auxR [maxTests];
	pcmLevel_t expL [maxTests];
	pcmLevel_t expR [maxTests];
	int tol [maxTests];

	audPcmDevice dut_i
	(
		.clock(clock),
		.reset(reset),
		.busReq(busReq),
		.busResp(busResp),
		.auxLeft(auxLeft),
		.auxRight(auxRight),
		.pwmOut(pwmOut),
		.pwmEnable(pwmEnable)
	);

	always #4 clock = ~clock;

	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	function automatic busResp_t busResponse(input logic [31:0] data, input busStatus_e status);
		busResp_t r;
		r.data = data;
		r.status = status;
		return r;
	endfunction

	task automatic checkBus(input string name, input busResp_t expected, input busResp_t actual);
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkLevel(input string name, input pcmLevel_t expected,
		input pcmLevel_t actual, input int tolerance);
		int diff;
		diff = int'(actual) - int'(expected);
		if (diff > tolerance || -diff > tolerance)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkPwm(input string name, input logic expEnable, input pwmPair_t expOut,
		input logic actEnable, input pwmPair_t actOut);
		if ({actEnable, actOut} !== {expEnable, expOut})
		begin
			errors++;
			$display("CHECK FAILED %s: expected enable %b out %b actual enable %b out %b",
				name, expEnable, expOut, actEnable, actOut);
		end
	endtask

	// one request cycle, then back to idle
	task automatic busAccess(input logic [31:0] addr, input logic [31:0] data, input logic [4:0] opm);
		busReq.addr = addr;
		busReq.data = data;
		busReq.opm = opm;
		nextCycle();
		busReq = '0;
	endtask

	// response is registered 2 cycles after the request
	task automatic busCheck(input string name, input logic [31:0] addr, input logic [31:0] data,
		input logic [4:0] opm, input busResp_t expected);
		busAccess(addr, data, opm);
		nextCycle();
		checkBus(name, expected, busResp);
	endtask

	// even slots take pattern A and odd slots pattern B
	function automatic logic [31:0] fillWord(input audCtrl_t ctrl, input logic [15:0] a,
		input logic [15:0] b);
		if (ctrl.format == LINEAR16)
			return {b, a};
		return {b[7:0], a[7:0], b[7:0], a[7:0]};
	endfunction

	// both banks in a shuffled order
	task automatic fillMemory(input logic [31:0] word);
		int j;
		int tmp;
		for (int i = 0; i < fillWrites; i++)
			fillOrder[i] = i;
		for (int i = fillWrites - 1; i > 0; i--)
		begin
			j = $urandom % (i + 1);
			tmp = fillOrder[i];
			fillOrder[i] = fillOrder[j];
			fillOrder[j] = tmp;
		end
		for (int i = 0; i < fillWrites; i++)
			busAccess(devBase | 32'((fillOrder[i] >> 1) << 3) | 32'((fillOrder[i] & 1) << 2),
				word, opmWrite);
	endtask

	task automatic countOnes(output pcmLevel_t left, output pcmLevel_t right);
		int onesL;
		int onesR;
		onesL = 0;
		onesR = 0;
		repeat (countCycles)
		begin
			nextCycle();
			onesL += pwmOut.left;
			onesR += pwmOut.right;
		end
		left = pcmLevel_t'(onesL);
		right = pcmLevel_t'(onesR);
	endtask

	task automatic runTest(input int t);
		pcmLevel_t left;
		pcmLevel_t right;
		auxLeft = auxL[t];
		auxRight = auxR[t];
		fillMemory(fillWord(audCtrl_t'(ctrlWord[t]), patA[t], patB[t]));
		busAccess(ctrlAddr, ctrlWord[t], opmWrite);
		repeat (settleCycles)
			nextCycle();
		countOnes(left, right);
		checkLevel({testName[t], " left"}, expL[t], left, tol[t]);
		checkLevel({testName[t], " right"}, expR[t], right, tol[t]);
	endtask

	// comment lines fail the scan and are skipped
	task automatic loadGolden();
		int fd;
		string line;
		fd = $fopen("test/audPcmGolden.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open the golden file test/audPcmGolden.txt");
			return;
		end
		while (!$feof(fd) && numTests < maxTests)
		begin
			void'($fgets(line, fd));
			if ($sscanf(line, "%s %h %h %h %h %h %h %h %d", testName[numTests],
				ctrlWord[numTests], patA[numTests], patB[numTests], auxL[numTests],
				auxR[numTests], expL[numTests], expR[numTests], tol[numTests]) == 9)
				numTests++;
		end
		$fclose(fd);
	endtask

	initial
	begin
		wait (numTests > 0);
		#(longint'(numTests) * (2 * slowPeriod + fillWrites + countCycles + 200) * 8);
		$display("run timed out after %0d tests worth of cycles", numTests);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		errors = 0;
		numTests = 0;
		clock = 1'b0;
		reset = 1'b1;
		busReq = '0;
		auxLeft = '0;
		auxRight = '0;
		void'($urandom(85));
		loadGolden();
		if (numTests == 0)
		begin
			errors++;
			$display("the golden file holds no tests");
		end
		repeat (2)
			@(posedge clock);
		#1;
		reset = 1'b0;
		nextCycle();

		checkPwm("after reset", 1'b0, pwmPair_t'(2'b11), pwmEnable, pwmOut);
		busCheck("ctrl write", ctrlAddr, 32'h5A3C_00F5, opmWrite, busResponse('0, OK));
		busCheck("ctrl read", ctrlAddr, '0, opmRead, busResponse(32'h5A3C_00F5, OK));
		busCheck("unselected read", otherAddr, '0, opmRead, busResponse('0, READY));
		busCheck("unselected write", otherAddr, 32'hFFFF_FFFF, opmWrite, busResponse('0, READY));

		for (int t = 0; t < numTests; t++)
			runTest(t);

		// disable and wait for the enable level to drop
		busAccess(ctrlAddr, 32'h0, opmWrite);
		for (int i = 0; i < 8 && pwmEnable; i++)
			nextCycle();
		checkPwm("disable", 1'b0, pwmPair_t'(2'b11), pwmEnable, pwmOut);

		$display("tests run %0d, errors %0d", numTests, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- test/audPcmGolden.txt
# name ctrl patA patB auxL auxR expL expR tol
# numbers in hex except tol, 8-bit formats use the low byte of each pattern
lin8_mid   00000008 0080 0080 00 00 8000 8000 0
lin8_pos   00000008 00ff 00ff 00 00 87f0 87f0 0
lin8_neg   00000008 0040 0040 00 00 7c00 7c00 0
cmp_e0_pos 00000009 0005 0005 00 00 800a 800a 0
cmp_e1_neg 00000009 009a 009a 00 00 7fcb 7fcb 0
cmp_e2_pos 00000009 0023 0023 00 00 804c 804c 0
cmp_e3_neg 00000009 00bc 00bc 00 00 7f19 7f19 0
cmp_e4_pos 00000009 0047 0047 00 00 8176 8176 0
cmp_e5_neg 00000009 00d9 00d9 00 00 7ccd 7ccd 0
cmp_e6_pos 00000009 006f 006f 00 00 87fc 87fc 0
cmp_e7_neg 00000009 00f1 00f1 00 00 8776 8776 0
lin16_aux  0000000a 9234 9234 10 f0 8223 8023 0
lin16_wrap 0000000a f000 f000 7f 80 8ef0 7f00 0
lin16_neg  0000000a 1000 1000 20 e0 7b00 7700 0
rate15_ab  000000f8 00c0 0040 00 00 8000 8000 2

//--- sources.f
+incdir+common
common/memBusPkg.sv
common/audPcmPkg.sv
audPcm/audRegBank.sv
audPcm/audSampleClock.sv
audPcm/audSampleDecoder.sv
audPcm/audMixPwm.sv
audPcm/audPcmDevice.sv
test/audPcmDeviceTb.sv
